/* src/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// PC loaded by reset
`define RV_RESET_PC 32'h0001_0000

// Data and address width
`define RV_XLEN 32

// Architectural registers
`define RV_NREGS 32

// ADDI x0,x0,0
`define RV_NOP 32'h0000_0013

// Access size code for a full word
`define RV_SIZE_WORD 2'b10

`endif

/* src/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    // RV32I major opcodes in the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0, // Zero so a cleared register is an add
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6  // LUI
    } alu_op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        alu_op_e             alu_op;
        logic                use_imm;   // B operand from immediate
        logic                use_pc;    // A operand from PC
        logic                reg_we;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                branch_ne; // BNE when set, BEQ otherwise
        logic                is_jump;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] result;     // ALU result, address or link value
        logic [`RV_XLEN-1:0] store_data;
        logic [4:0]          rd;
        logic                reg_we;
        logic                is_load;
        logic                is_store;
        logic                redirect;
        logic [`RV_XLEN-1:0] target;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] value;
        logic [4:0]          rd;
        logic                reg_we;
    } mem_wb_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic                we;
        logic [`RV_XLEN-1:0] wdata;
        logic [1:0]          size;
    } dmem_req_t;

endpackage

/* src/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output if_id_t              if_id
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;

    // Redirect comes from the memory stage, three fetches late
    assign pc_next   = redirect ? redirect_pc : pc + 32'd4;
    assign imem_addr = pc; // Memory answers in the same cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // Fetch-to-decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.pc    <= `RV_RESET_PC;
            if_id.instr <= `RV_NOP;
        end else if (!stall) begin
            if_id.pc    <= pc;
            if_id.instr <= imem_rdata;
        end
    end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  logic                wr_en,
    input  logic [4:0]          wr_addr,
    input  logic [`RV_XLEN-1:0] wr_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 reads zero, a write in flight is seen by the reader
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (wr_en && wr_addr == addr)
            return wr_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // x0 must stay zero across every writeback
    a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  if_id_t              if_id,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output id_ex_t              id_ex
);

    logic [`RV_XLEN-1:0] instr;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic                opc_known;
    id_ex_t              d;

    assign instr    = if_id.instr;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // SUB only exists in the register form
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        d         = '0;
        d.pc      = if_id.pc;
        d.rs1_val = rs1_data;
        d.rs2_val = rs2_data;
        d.rd      = instr[11:7];
        opc_known = 1'b1;
        case (opcode)
            OP: begin
                d.reg_we = 1'b1;
                d.alu_op = alu_from_funct(funct3, instr[30]);
            end
            OP_IMM: begin
                d.reg_we  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = imm_i;
                d.alu_op  = alu_from_funct(funct3, 1'b0);
            end
            LUI: begin
                d.reg_we  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = imm_u;
                d.alu_op  = ALU_PASS_B;
            end
            AUIPC: begin
                d.reg_we  = 1'b1;
                d.use_pc  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = imm_u;
            end
            LOAD: begin
                d.reg_we  = 1'b1;
                d.is_load = 1'b1;
                d.use_imm = 1'b1; // Address is rs1 + offset
                d.imm     = imm_i;
            end
            STORE: begin
                d.is_store = 1'b1;
                d.use_imm  = 1'b1;
                d.imm      = imm_s;
            end
            BRANCH: begin
                d.is_branch = 1'b1;
                d.branch_ne = funct3[0];
                d.imm       = imm_b;
            end
            JAL: begin
                d.reg_we  = 1'b1;
                d.is_jump = 1'b1;
                d.imm     = imm_j;
            end
            default: begin
                d         = '0; // Unknown opcode runs as a NOP
                opc_known = 1'b0;
            end
        endcase
    end

    // Decode-to-execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= d;
        end
    end

    // Fetched words must stay inside the supported subset
    a_opcode_known: assert property (@(posedge clk) disable iff (rst) !stall |-> opc_known);

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] target;
    logic                equal;
    logic                taken;

    assign op_a = id_ex.use_pc  ? id_ex.pc  : id_ex.rs1_val;
    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    // Branch compare works on the register values
    assign equal  = id_ex.rs1_val == id_ex.rs2_val;
    assign taken  = id_ex.is_branch && (equal != id_ex.branch_ne);
    assign target = id_ex.pc + id_ex.imm;

    // Execute-to-memory register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.result     <= id_ex.is_jump ? id_ex.pc + 32'd4 : alu_y; // Link value
            ex_mem.store_data <= id_ex.rs2_val;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
            ex_mem.redirect   <= id_ex.is_jump || taken;
            ex_mem.target     <= target;
        end
    end

endmodule

/* src/rv_mem_stage.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_mem_stage
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  ex_mem_t             ex_mem,
    output logic                dmem_valid,
    input  logic                dmem_ready,
    output dmem_req_t           dmem_req,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic                stall,
    output logic                wb_en,
    output logic [4:0]          wb_addr,
    output logic [`RV_XLEN-1:0] wb_data
);

    mem_wb_t mem_wb;

    assign dmem_valid     = ex_mem.is_load | ex_mem.is_store;
    assign dmem_req.addr  = ex_mem.result;
    assign dmem_req.we    = ex_mem.is_store;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.size  = `RV_SIZE_WORD;

    // Whole pipeline waits on an unanswered request
    assign stall = dmem_valid & ~dmem_ready;

    // Memory-to-writeback register, a bubble while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.value  <= ex_mem.is_load ? dmem_rdata : ex_mem.result;
            mem_wb.rd     <= ex_mem.rd;
            mem_wb.reg_we <= ex_mem.reg_we & ~stall;
        end
    end

    assign wb_en   = mem_wb.reg_we;
    assign wb_addr = mem_wb.rd;
    assign wb_data = mem_wb.value;

    // Request held until the handshake completes
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req));

    a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        dmem_valid |-> dmem_req.addr[1:0] == 2'b00);

endmodule

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // Instruction memory, combinational read
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_rdata,

    // Data memory, valid/ready
    output logic                dmem_valid,
    input  logic                dmem_ready,
    output dmem_req_t           dmem_req,
    input  logic [`RV_XLEN-1:0] dmem_rdata
);

    logic                stall;
    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                wb_en;
    logic [4:0]          wb_addr;
    logic [`RV_XLEN-1:0] wb_data;

    rv_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (ex_mem.redirect), // Registered in the memory stage
        .redirect_pc (ex_mem.target),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .if_id       (if_id)
    );

    rv_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .if_id    (if_id),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data)
    );

    rv_execute u_execute (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    rv_mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .stall      (stall),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core
    import rv_pkg::*;
();

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 1024;
    localparam int BODY_LEN   = 200;        // Words of random code before the dump
    localparam logic [11:0] SCRATCH   = 12'h400;
    localparam logic [11:0] DUMP_BASE = 12'h600;
    localparam logic [17:0] R_F3 = {3'b111, 3'b110, 3'b100, 3'b010, 3'b000, 3'b000};
    localparam logic [11:0] I_F3 = {3'b111, 3'b110, 3'b100, 3'b000};

    logic                clk;
    logic                rst;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_rdata;
    logic                dmem_valid;
    logic                dmem_ready;
    dmem_req_t           dmem_req;
    logic [`RV_XLEN-1:0] dmem_rdata;

    logic [31:0] prog [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    int          ready_at [32];       // First program index allowed to read each register
    int          n_prog;
    logic [31:0] halt_pc;
    dmem_req_t   exp_q [$];
    int          store_idx;
    int          load_count;
    bit          random_mode;
    integer      seed = 32'h9a01;

    rv_core_top DUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Program sits at the reset PC, which is 4 KB aligned
    assign imem_rdata = prog[imem_addr[11:2]];

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h0001_0193) ^ 32'hc3a5_0f1e;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_e op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog[n_prog] = word;
        n_prog++;
    endfunction

    // Pad with NOPs until both sources are written back
    function automatic void wait_regs(input int a, input int b);
        while (n_prog < ready_at[a] || n_prog < ready_at[b]) begin
            emit(`RV_NOP);
        end
    endfunction

    function automatic void mark_written(input int rd);
        ready_at[rd] = n_prog + 2;
    endfunction

    function automatic void gen_program();
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] off;
        int          pick;
        n_prog = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = `RV_NOP;
        end
        for (int r = 0; r < 32; r++) begin
            ready_at[r] = 0;
        end
        emit(s_type(SCRATCH, 5'd0, 5'd0)); // Leading store, earliest memory access after reset
        while (n_prog < BODY_LEN) begin
            rd  = 5'(1 + rnd(31));
            rs1 = 5'(rnd(32));
            rs2 = 5'(rnd(32));
            case (rnd(9))
                0, 1: begin
                    pick = rnd(6); // Slot 1 is SUB
                    wait_regs(rs1, rs2);
                    emit(r_type(pick == 1 ? 7'b0100000 : 7'b0, rs2, rs1, R_F3[pick*3 +: 3], rd));
                    mark_written(rd);
                end
                2, 3: begin
                    wait_regs(rs1, 0);
                    emit(i_type(12'($random(seed)), rs1, I_F3[rnd(4)*3 +: 3], rd, OP_IMM));
                    mark_written(rd);
                end
                4: begin
                    emit(u_type(20'($random(seed)), rd, rnd(2) ? LUI : AUIPC));
                    mark_written(rd);
                end
                5: begin
                    // Store, reload the same word, then store the loaded register back
                    off = SCRATCH + 12'(4 * rnd(16));
                    wait_regs(0, rs2);
                    emit(s_type(off, rs2, 5'd0));
                    emit(i_type(off, 5'd0, 3'b010, rd, LOAD));
                    mark_written(rd);
                    wait_regs(rd, 0);
                    emit(s_type(off, rd, 5'd0));
                end
                6, 7: if (n_prog + 10 <= BODY_LEN) begin
                    wait_regs(rs1, rs2);
                    emit(b_type(13'(16 + 4 * rnd(4)), rs2, rs1, rnd(2) ? 3'b001 : 3'b000));
                    repeat (3) emit(`RV_NOP); // Slots after the branch
                end
                default: if (n_prog + 10 <= BODY_LEN) begin
                    emit(j_type(21'(16 + 4 * rnd(4)), rd));
                    mark_written(rd);
                    repeat (3) emit(`RV_NOP);
                end
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            wait_regs(r, 0);
            emit(s_type(DUMP_BASE + 12'(4 * r), 5'(r), 5'd0));
        end
        halt_pc = `RV_RESET_PC + 32'(4 * n_prog);
        emit(j_type(21'd0, 5'd0)); // Spin here, NOPs follow
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-level model, fills exp_q with the stores in program order
    function automatic bit run_iss();
        logic [31:0] x [32];
        logic [31:0] mem [DMEM_WORDS];
        logic [31:0] pc, ins, a, b, imm_i, imm_u, addr, res, npc;
        logic [4:0]  rd;
        logic        wr;
        dmem_req_t   req;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fill_word(32'(i) << 2);
        end
        pc    = `RV_RESET_PC;
        steps = 0;
        while (pc != halt_pc && steps < 4 * IMEM_WORDS) begin
            ins   = prog[pc[11:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            rd    = ins[11:7];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_u = {ins[31:12], 12'b0};
            res   = '0;
            wr    = 1'b1;
            npc   = pc + 32'd4;
            case (ins[6:0])
                OP:     res = alu_ref(ins[14:12], ins[30], a, b);
                OP_IMM: res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                LUI:    res = imm_u;
                AUIPC:  res = pc + imm_u;
                LOAD: begin
                    addr = a + imm_i;
                    res  = mem[addr[11:2]];
                end
                STORE: begin
                    wr        = 1'b0;
                    addr      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[11:2]] = b;
                    req.addr  = addr;
                    req.we    = 1'b1;
                    req.wdata = b;
                    req.size  = `RV_SIZE_WORD;
                    exp_q.push_back(req);
                end
                BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12]) begin // funct3 bit 0 selects BNE
                        npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                JAL: begin
                    res = pc + 32'd4;
                    npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                x[rd] = res;
            end
            pc = npc;
            steps++;
        end
        return pc == halt_pc;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "** Error at %0d ns: dmem_req got %h/%b/%h/%b, expected %h/%b/%h/%b",
                $time, got.addr, got.we, got.wdata, got.size,
                exp.addr, exp.we, exp.wdata, exp.size));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0d ns: dmem_valid got %b, expected %b",
                                     $time, got, exp));
        end
    endtask

    task automatic check_fetch_addr(input logic [`RV_XLEN-1:0] got,
                                    input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0d ns: imem_addr got %h, expected %h",
                                     $time, got, exp));
        end
    endtask

    // Data memory, inputs change on the falling edge
    always @(negedge clk) begin
        dmem_ready = random_mode ? 1'($random(seed)) : 1'b1;
        dmem_rdata = dmem[dmem_req.addr[11:2]];
    end

    always @(posedge clk) begin
        if (!rst && dmem_valid && dmem_ready && dmem_req.we) begin
            dmem[dmem_req.addr[11:2]] = dmem_req.wdata;
        end
    end

    // Store checker, loads only counted
    always @(posedge clk) begin
        if (!rst && dmem_valid && dmem_ready) begin
            if (dmem_req.addr >= 4 * DMEM_WORDS) begin
                report_failure("Data access outside the modeled memory");
            end else if (!dmem_req.we) begin
                load_count++;
            end else if (store_idx >= exp_q.size()) begin
                report_failure("Store seen after the last expected store");
            end else begin
                check_store(dmem_req, exp_q[store_idx]);
                store_idx++;
            end
        end
    end

    task automatic run_program(input bit random_ready);
        int cycles;
        int limit;
        random_mode = random_ready;
        store_idx   = 0;
        load_count  = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(32'(i) << 2);
        end
        rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_valid(dmem_valid, 1'b0);
            check_fetch_addr(imem_addr, `RV_RESET_PC);
        end
        rst = 1'b0;
        // Values seen by the first three rising edges after release
        repeat (2) begin
            @(negedge clk);
            check_valid(dmem_valid, 1'b0);
        end
        limit  = n_prog * 8 + 50;
        cycles = 0;
        while (store_idx < exp_q.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles >= limit) begin
                report_failure("Timeout, the core stalled before all expected stores were seen");
            end
        end
        $display("Run done (random ready %0b): %0d stores, %0d loads, %0d cycles",
                 random_ready, store_idx, load_count, cycles);
    endtask

    initial begin
        rst         = 1'b1;
        dmem_ready  = 1'b1;
        dmem_rdata  = '0;
        random_mode = 1'b0;
        gen_program();
        if (!run_iss()) begin
            report_failure("Reference model did not reach the end of the program");
        end
        $display("Program of %0d words, %0d stores expected", n_prog, exp_q.size());
        run_program(1'b0);
        run_program(1'b1); // Same program under back-pressure
        if (load_count > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("No load handshake was seen during the run");
        end
    end

endmodule

/* build.f */
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_mem_stage.sv
src/rv_core_top.sv
test/tb_rv_core.sv
